// ==== Makefile ====
# Verilator build and run of the load/store queue testbench

VERILATOR ?= verilator
TOP       ?= tb_lsq
FILELIST  ?= files.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LFLAGS    ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== files.f ====
lsq_pkg.sv
lsq_alloc.sv
lsq_entry.sv
lsq_issue.sv
lsq_top.sv
lsq_sva.sv
tb_lsq.sv

// ==== lsq_alloc.sv ====
`timescale 1ns/1ps

module lsq_alloc
    import lsq_pkg::*;
#(
    parameter int LSQ_DEPTH = 4
)
(
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 up_valid,
    output logic                 up_ready,
    input  up_req_t              up_req,

    input  logic [LSQ_DEPTH-1:0] busy,
    input  nline_t               refill_id,

    output logic [LSQ_DEPTH-1:0] enq_sel,
    output lsq_req_t             enq_req,
    output set_t                 refill_set,
    output way_t                 refill_way
);

    logic [LSQ_DEPTH-1:0] free;
    logic [LSQ_DEPTH-1:0] first_free;
    logic                 up_hsk;

    // ------------------------------
    // slot choice
    // ------------------------------
    assign free       = ~busy;
    assign first_free = free & (~free + 1'b1);  // lowest set bit
    assign up_ready   = |free;
    assign up_hsk     = up_valid && up_ready;
    assign enq_sel    = up_hsk ? first_free : '0;

    // ------------------------------
    // line id split
    // ------------------------------
    always_comb
    begin
        enq_req.chan = up_req.chan;
        enq_req.op   = up_req.op;
        enq_req.set  = up_req.id[SET_W-1:0];
        enq_req.way  = up_req.id[SET_W +: WAY_W];
        enq_req.wbuf = up_req.wbuf;
    end

    assign refill_set = refill_id[SET_W-1:0];
    assign refill_way = refill_id[SET_W +: WAY_W];

endmodule

// ==== lsq_entry.sv ====
`timescale 1ns/1ps

module lsq_entry
    import lsq_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     enq,
    input  lsq_req_t enq_req,
    input  logic     enq_inflight,

    input  logic     refill_valid,
    input  set_t     refill_set,
    input  way_t     refill_way,

    input  logic     deq_grant,

    output logic     busy,
    output logic     deq_valid,
    output lsq_req_t deq_req
);

    logic     vld;
    logic     inflight;
    lsq_req_t ent;
    logic     enq_hit;
    logic     ent_hit;
    logic     evict;

    // refill matching the incoming or the held line
    assign enq_hit = refill_valid && (refill_set == enq_req.set) && (refill_way == enq_req.way);
    assign ent_hit = refill_valid && (refill_set == ent.set) && (refill_way == ent.way);
    assign evict   = is_evict(ent.op);

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            vld <= 1'b0;
        end
        else if (enq)
        begin
            vld <= 1'b1;
        end
        else if (deq_grant && !evict)
        begin
            vld <= 1'b0;  // evicting ops stay for the refill phase
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            inflight <= 1'b0;
        end
        else if (enq)
        begin
            inflight <= enq_inflight && !enq_hit;
        end
        else if (ent_hit)
        begin
            inflight <= 1'b0;
        end
    end

    // ------------------------------
    // payload
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            ent <= enq_req;
        end
        else if (deq_grant && evict)
        begin
            ent.op <= refill_of(ent.op);  // writeback done, refill next
        end
    end

    assign busy      = vld;
    assign deq_valid = vld && !inflight;

    always_comb
    begin
        deq_req = ent;
        if (evict)
        begin
            deq_req.op = OP_WB;
        end
    end

endmodule

// ==== lsq_issue.sv ====
`timescale 1ns/1ps

module lsq_issue
    import lsq_pkg::*;
#(
    parameter int LSQ_DEPTH = 4
)
(
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic [LSQ_DEPTH-1:0] enq_sel,
    input  logic [LSQ_DEPTH-1:0] busy,
    input  logic [LSQ_DEPTH-1:0] deq_valid,
    input  lsq_req_t             deq_req [LSQ_DEPTH],

    output logic [LSQ_DEPTH-1:0] deq_grant,

    output logic                 rc_valid,
    input  logic                 rc_ready,
    output lsq_req_t             rc_req,

    output logic                 crdt_valid,
    output crdt_t                crdt,
    output logic                 refill_confirm
);

    localparam int IDX_W = (LSQ_DEPTH > 1) ? $clog2(LSQ_DEPTH) : 1;

    logic [LSQ_DEPTH-1:0] older [LSQ_DEPTH];  // older[i][j] set when slot i came before j
    logic [LSQ_DEPTH-1:0] sel;
    logic [IDX_W-1:0]     gnt_idx;
    logic                 real_issue;

    // ------------------------------
    // age matrix
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < LSQ_DEPTH; i++)
            begin
                older[i] <= '0;
            end
        end
        else
        begin
            for (int k = 0; k < LSQ_DEPTH; k++)
            begin
                if (enq_sel[k])
                begin
                    older[k] <= '0;  // new slot is the youngest
                    for (int j = 0; j < LSQ_DEPTH; j++)
                    begin
                        if (j != k)
                        begin
                            older[j][k] <= busy[j];
                        end
                    end
                end
            end
        end
    end

    // oldest ready slot
    always_comb
    begin
        for (int i = 0; i < LSQ_DEPTH; i++)
        begin
            sel[i] = deq_valid[i];
            for (int j = 0; j < LSQ_DEPTH; j++)
            begin
                if (deq_valid[j] && older[j][i])
                begin
                    sel[i] = 1'b0;
                end
            end
        end
    end

    always_comb
    begin
        gnt_idx = '0;
        for (int i = 0; i < LSQ_DEPTH; i++)
        begin
            if (sel[i])
            begin
                gnt_idx = IDX_W'(i);
            end
        end
    end

    // ------------------------------
    // downstream and credit
    // ------------------------------
    assign rc_valid  = |deq_valid;
    assign rc_req    = deq_req[gnt_idx];
    assign deq_grant = sel & {LSQ_DEPTH{rc_ready}};

    assign real_issue     = rc_valid && rc_ready && (rc_req.op != OP_WB);
    assign crdt_valid     = real_issue;
    assign refill_confirm = real_issue;
    assign crdt.id        = {rc_req.way, rc_req.set};

endmodule

// ==== lsq_pkg.sv ====
package lsq_pkg;

    // ------------------------------
    // field widths
    // ------------------------------
    localparam int SET_W  = 6;
    localparam int WAY_W  = 2;
    localparam int WBUF_W = 3;
    localparam int CHAN_W = 3;

    typedef logic [SET_W-1:0]       set_t;
    typedef logic [WAY_W-1:0]       way_t;
    typedef logic [WBUF_W-1:0]      wbuf_t;
    typedef logic [WAY_W+SET_W-1:0] nline_t;  // {way, set}
    typedef logic [CHAN_W-1:0]      chan_t;   // one-hot

    typedef enum logic [2:0]
    {
        OP_LOAD         = 3'd0,
        OP_STORE        = 3'd1,
        OP_RAE          = 3'd2,  // read, allocate, evict
        OP_WAE          = 3'd3,  // write, allocate, evict
        OP_LOAD_REFILL  = 3'd4,
        OP_STORE_REFILL = 3'd5,
        OP_WB           = 3'd6
    } cache_op_e;

    // ------------------------------
    // request formats
    // ------------------------------
    typedef struct packed
    {
        chan_t     chan;
        cache_op_e op;
        set_t      set;
        way_t      way;
        wbuf_t     wbuf;
    } lsq_req_t;

    typedef struct packed
    {
        chan_t     chan;
        cache_op_e op;
        nline_t    id;
        wbuf_t     wbuf;
    } up_req_t;

    typedef struct packed
    {
        nline_t id;
    } crdt_t;

    function automatic logic is_evict(cache_op_e op);
        return (op == OP_RAE) || (op == OP_WAE);
    endfunction

    // second phase of an evicting op
    function automatic cache_op_e refill_of(cache_op_e op);
        return (op == OP_RAE) ? OP_LOAD_REFILL : OP_STORE_REFILL;
    endfunction

endpackage

// ==== lsq_sva.sv ====
`timescale 1ns/1ps

module lsq_sva
    import lsq_pkg::*;
#(
    parameter int LSQ_DEPTH = 4
)
(
    input logic                 clk,
    input logic                 arst_n,
    input logic [LSQ_DEPTH-1:0] busy,
    input logic [LSQ_DEPTH-1:0] deq_grant,
    input logic                 rc_valid,
    input logic                 rc_ready,
    input lsq_req_t             rc_req
);

    // ------------------------------
    // grant and handshake
    // ------------------------------
    grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        (rc_valid && rc_ready) |-> $onehot(deq_grant))
        else $error("handshake without exactly one granted slot");

    rc_valid_holds: assert property (@(posedge clk) disable iff (!arst_n)
        (rc_valid && !rc_ready) |=> rc_valid)
        else $error("rc_valid dropped without a handshake");

    // ------------------------------
    // slot release
    // ------------------------------
    wb_keeps_slot: assert property (@(posedge clk) disable iff (!arst_n)
        (rc_valid && rc_ready && rc_req.op == OP_WB)
        |=> rc_valid && ((busy & $past(deq_grant)) != '0))
        else $error("writeback freed its slot or left no refill to issue");

    issue_frees_slot: assert property (@(posedge clk) disable iff (!arst_n)
        (rc_valid && rc_ready && rc_req.op != OP_WB)
        |=> ((busy & $past(deq_grant)) == '0))
        else $error("slot still busy after its last issue");

endmodule

bind lsq_issue lsq_sva #(
    .LSQ_DEPTH (LSQ_DEPTH)
) lsq_sva_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .busy      (busy),
    .deq_grant (deq_grant),
    .rc_valid  (rc_valid),
    .rc_ready  (rc_ready),
    .rc_req    (rc_req)
);

// ==== lsq_top.sv ====
`timescale 1ns/1ps

module lsq_top
    import lsq_pkg::*;
#(
    parameter int LSQ_DEPTH = 4
)
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     up_valid,
    output logic     up_ready,
    input  up_req_t  up_req,
    input  logic     up_inflight,

    input  logic     refill_valid,
    input  nline_t   refill_id,

    output logic     rc_valid,
    input  logic     rc_ready,
    output lsq_req_t rc_req,

    output logic     crdt_valid,
    output crdt_t    crdt,
    output logic     refill_confirm
);

    logic [LSQ_DEPTH-1:0] enq_sel;
    lsq_req_t             enq_req;
    set_t                 refill_set;
    way_t                 refill_way;
    logic [LSQ_DEPTH-1:0] busy;
    logic [LSQ_DEPTH-1:0] deq_valid;
    lsq_req_t             deq_req [LSQ_DEPTH];
    logic [LSQ_DEPTH-1:0] deq_grant;

    lsq_alloc #(
        .LSQ_DEPTH (LSQ_DEPTH)
    ) lsq_alloc_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .up_valid   (up_valid),
        .up_ready   (up_ready),
        .up_req     (up_req),
        .busy       (busy),
        .refill_id  (refill_id),
        .enq_sel    (enq_sel),
        .enq_req    (enq_req),
        .refill_set (refill_set),
        .refill_way (refill_way)
    );

    // ------------------------------
    // entry array
    // ------------------------------
    for (genvar i = 0; i < LSQ_DEPTH; i++)
    begin : entry_gen
        lsq_entry lsq_entry_i (
            .clk          (clk),
            .arst_n       (arst_n),
            .enq          (enq_sel[i]),
            .enq_req      (enq_req),
            .enq_inflight (up_inflight),  // only sampled on enqueue
            .refill_valid (refill_valid),
            .refill_set   (refill_set),
            .refill_way   (refill_way),
            .deq_grant    (deq_grant[i]),
            .busy         (busy[i]),
            .deq_valid    (deq_valid[i]),
            .deq_req      (deq_req[i])
        );
    end

    lsq_issue #(
        .LSQ_DEPTH (LSQ_DEPTH)
    ) lsq_issue_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .enq_sel        (enq_sel),
        .busy           (busy),
        .deq_valid      (deq_valid),
        .deq_req        (deq_req),
        .deq_grant      (deq_grant),
        .rc_valid       (rc_valid),
        .rc_ready       (rc_ready),
        .rc_req         (rc_req),
        .crdt_valid     (crdt_valid),
        .crdt           (crdt),
        .refill_confirm (refill_confirm)
    );

endmodule

// ==== tb_lsq.sv ====
`timescale 1ns/1ps

module tb_lsq;
    import lsq_pkg::*;

    localparam int LSQ_DEPTH = 4;

    logic     clk;
    logic     arst_n;
    logic     up_valid;
    logic     up_ready;
    up_req_t  up_req;
    logic     up_inflight;
    logic     refill_valid;
    nline_t   refill_id;
    logic     rc_valid;
    logic     rc_ready;
    lsq_req_t rc_req;
    logic     crdt_valid;
    crdt_t    crdt;
    logic     refill_confirm;

    int unsigned seed = 59;
    int          mismatches;
    int          errors;
    int          tag_cnt;
    lsq_req_t    exp_req [$];   // expected issues, oldest first
    int          exp_tag [$];   // request each issue belongs to
    bit          exp_wait [$];  // line refill still outstanding

    lsq_top #(
        .LSQ_DEPTH (LSQ_DEPTH)
    ) lsq_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned next_rand();
        seed = seed * 1103515245 + 12345;
        return seed >> 16;
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic int expected_issues(up_req_t r, output lsq_req_t first,
                                           output lsq_req_t second);
        first.chan = r.chan;
        first.op   = r.op;
        first.set  = r.id[SET_W-1:0];  // way sits above the set
        first.way  = r.id[SET_W +: WAY_W];
        first.wbuf = r.wbuf;
        second     = first;
        case (r.op)
            OP_RAE:
            begin
                first.op  = OP_WB;
                second.op = OP_LOAD_REFILL;
                return 2;
            end
            OP_WAE:
            begin
                first.op  = OP_WB;
                second.op = OP_STORE_REFILL;
                return 2;
            end
            default:
                return 1;
        endcase
    endfunction

    // no earlier issue of the same request still pending
    function automatic bit is_next_of_request(int i);
        for (int j = 0; j < i; j++)
        begin
            if (exp_tag[j] == exp_tag[i])
            begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------
    // compare downstream handshakes
    // ------------------------------
    always @(negedge clk)
    begin
        int       idx;
        int       n;
        lsq_req_t a;
        lsq_req_t b;
        if (arst_n)
        begin
            idx = -1;
            if (rc_valid && rc_ready)
            begin
                for (int i = 0; i < exp_req.size() && idx < 0; i++)
                begin
                    if (!exp_wait[i] && is_next_of_request(i)
                        && exp_req[i].way == rc_req.way && exp_req[i].set == rc_req.set)
                    begin
                        idx = i;  // oldest eligible on this line
                    end
                end
                if (idx < 0)
                begin
                    errors++;
                    $display("ERROR: line %h issued with no eligible request waiting for it",
                             {rc_req.way, rc_req.set});
                end
                else
                begin
                    check("issue", 32'(exp_req[idx]), 32'(rc_req));
                    check("credit_valid", 32'(exp_req[idx].op != OP_WB), 32'(crdt_valid));
                    check("refill_confirm", 32'(exp_req[idx].op != OP_WB), 32'(refill_confirm));
                    if (exp_req[idx].op != OP_WB)
                    begin
                        check("credit_id", 32'({exp_req[idx].way, exp_req[idx].set}),
                              32'(crdt.id));
                    end
                    exp_req.delete(idx);
                    exp_tag.delete(idx);
                    exp_wait.delete(idx);
                end
            end
            else
            begin
                check("idle_credit", 0, 32'({crdt_valid, refill_confirm}));
            end
            if (refill_valid)
            begin
                for (int i = 0; i < exp_req.size(); i++)
                begin
                    if ({exp_req[i].way, exp_req[i].set} == refill_id)
                    begin
                        exp_wait[i] = 1'b0;
                    end
                end
            end
            if (up_valid && up_ready)
            begin
                n = expected_issues(up_req, a, b);
                exp_req.push_back(a);
                exp_tag.push_back(tag_cnt);
                exp_wait.push_back(up_inflight && !(refill_valid && refill_id == up_req.id));
                if (n == 2)
                begin
                    exp_req.push_back(b);
                    exp_tag.push_back(tag_cnt);
                    exp_wait.push_back(exp_wait[exp_wait.size() - 1]);
                end
                tag_cnt++;
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic new_request(bit inflight);
        up_valid    = 1'b1;
        up_inflight = inflight;
        up_req.chan = chan_t'(3'b001 << (next_rand() % 3));
        up_req.op   = cache_op_e'(next_rand() % 4);
        up_req.id   = {way_t'(next_rand() % 2), set_t'(next_rand() % 3)};  // few lines
        up_req.wbuf = wbuf_t'(next_rand());
    endtask

    task automatic run_traffic(int n_req);
        int sent;
        int cyc;
        bit took;
        sent = 0;
        cyc  = 0;
        while ((sent < n_req || exp_req.size() > 0) && cyc < 200 + 40 * n_req)
        begin
            @(negedge clk);
            took = up_valid && up_ready;
            @(posedge clk);
            #1;
            cyc++;
            if (took)
            begin
                sent++;
                up_valid = 1'b0;
            end
            refill_valid = 1'b0;
            rc_ready     = (next_rand() % 4) != 0;
            if (!up_valid && sent < n_req)
            begin
                new_request((next_rand() % 3) == 0);
                if ((next_rand() % 4) == 0)
                begin
                    refill_valid = 1'b1;  // same-cycle refill
                    refill_id    = up_req.id;
                end
            end
            else if ((next_rand() % 6) == 0)
            begin
                for (int i = 0; i < exp_req.size(); i++)
                begin
                    if (exp_wait[i])
                    begin
                        refill_valid = 1'b1;
                        refill_id    = {exp_req[i].way, exp_req[i].set};
                    end
                end
            end
        end
        if (sent < n_req || exp_req.size() > 0)
        begin
            errors++;
            $display("ERROR: traffic did not drain, %0d sent and %0d issues still pending",
                     sent, exp_req.size());
        end
    endtask

    task automatic fill_under_stall();
        int accepts;
        bit took;
        accepts  = 0;
        rc_ready = 1'b0;
        for (int cyc = 0; cyc < 4 * LSQ_DEPTH; cyc++)
        begin
            @(negedge clk);
            took = up_valid && up_ready;
            @(posedge clk);
            #1;
            if (took)
            begin
                accepts++;
                up_valid = 1'b0;
            end
            refill_valid = 1'b0;
            if (!up_valid)
            begin
                new_request(1'b0);
            end
        end
        @(negedge clk);
        check("stall_accepts", LSQ_DEPTH, accepts);
        check("stall_up_ready", 0, 32'(up_ready));
        @(posedge clk);
        #1;
        up_valid = 1'b0;
    endtask

    initial
    begin
        mismatches   = 0;
        errors       = 0;
        tag_cnt      = 0;
        arst_n       = 1'b0;
        up_valid     = 1'b0;
        up_req       = '0;
        up_inflight  = 1'b0;
        refill_valid = 1'b0;
        refill_id    = '0;
        rc_ready     = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check("reset_up_ready", 1, 32'(up_ready));
        check("reset_rc_valid", 0, 32'(rc_valid));
        @(posedge clk);
        #1;
        run_traffic(300);
        fill_under_stall();
        run_traffic(0);
        run_traffic(200);
        $display("errors: %0d mismatches, %0d other failures", mismatches, errors);
        if (mismatches == 0 && errors == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
